/* hw/dds_params.svh */
`ifndef DDS_PARAMS_SVH
`define DDS_PARAMS_SVH

// sample and datapath widths
`define DDS_SAMPLE_W 8
`define DDS_PHASE_W 32
`define DDS_LUT_AW 8
// gain is unsigned, 8 fraction bits
`define DDS_GAIN_W 16
`define DDS_FM_SHIFT 16
`define DDS_PRBS_SEED 8'h01

// apb side
`define DDS_ADDR_W 8
`define DDS_DATA_W 32
// word registers from 0x00 up to STAT_COUNT
`define DDS_REG_COUNT 11

`endif

/* hw/dds_reg_pkg.sv */
`include "dds_params.svh"

package dds_reg_pkg;

    // byte offsets of the word registers
    typedef enum logic [`DDS_ADDR_W-1:0] {
        REG_SRC         = 8'h00,
        REG_RAW         = 8'h04,
        REG_STEP        = 8'h08,
        REG_FM_CFG      = 8'h0C,
        REG_GAIN        = 8'h10,
        REG_OFFSET      = 8'h14,
        REG_PHASE_CLR   = 8'h18,
        REG_STAT_CFG    = 8'h1C,
        REG_STAT_LIMIT  = 8'h20,
        REG_STAT_MINMAX = 8'h24,
        REG_STAT_COUNT  = 8'h28
    } reg_addr_e;

    // FM_CFG layout, fm raw sample sits in 15:8
    typedef struct packed {
        logic [`DDS_GAIN_W-1:0]   gain;
        logic [`DDS_SAMPLE_W-1:0] raw;
        logic [5:0]               rsvd;
        logic [1:0]               src;
    } fm_cfg_t;

    // STAT_CFG layout
    typedef struct packed {
        logic [`DDS_DATA_W-3:0] rsvd;
        logic                   enable;
        logic                   clear;
    } stat_cfg_t;

    // STAT_MINMAX layout, read only
    typedef struct packed {
        logic [`DDS_DATA_W-2*`DDS_SAMPLE_W-1:0] rsvd;
        logic [`DDS_SAMPLE_W-1:0]               max;
        logic [`DDS_SAMPLE_W-1:0]               min;
    } stat_minmax_t;

endpackage

/* hw/dds_sig_pkg.sv */
`include "dds_params.svh"

package dds_sig_pkg;

    typedef logic signed [`DDS_SAMPLE_W-1:0] sample_t;

    // full scale of a sample
    localparam sample_t SAMPLE_MAX = sample_t'(2 ** (`DDS_SAMPLE_W - 1) - 1);
    localparam sample_t SAMPLE_MIN = sample_t'(-(2 ** (`DDS_SAMPLE_W - 1)));

    // output source select, 6 and 7 behave as zero
    typedef enum logic [2:0] {
        SRC_RAW  = 3'd0,
        SRC_INA  = 3'd1,
        SRC_INB  = 3'd2,
        SRC_DDS  = 3'd3,
        SRC_PRBS = 3'd4,
        SRC_ZERO = 3'd5
    } src_sel_e;

    // fm modulation source
    typedef enum logic [1:0] {
        FM_RAW = 2'd0,
        FM_INA = 2'd1,
        FM_INB = 2'd2,
        FM_OFF = 2'd3
    } fm_src_e;

endpackage

/* hw/dds_regs.sv */
`timescale 1ns/1ps
`include "dds_params.svh"

module dds_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`DDS_ADDR_W-1:0]     paddr,
    input  logic [`DDS_DATA_W-1:0]     pwdata,
    output logic [`DDS_DATA_W-1:0]     prdata,
    output dds_sig_pkg::src_sel_e      src_sel,
    output dds_sig_pkg::sample_t       raw,
    output logic [`DDS_PHASE_W-1:0]    step,
    output dds_sig_pkg::fm_src_e       fm_src,
    output dds_sig_pkg::sample_t       fm_raw,
    output logic [`DDS_GAIN_W-1:0]     fm_gain,
    output logic [`DDS_GAIN_W-1:0]     gain,
    output dds_sig_pkg::sample_t       offset,
    output logic                       phase_clr,
    output logic                       stat_clear,
    output logic                       stat_enable,
    output logic [`DDS_DATA_W-1:0]     stat_limit,
    input  dds_sig_pkg::sample_t       stat_min,
    input  dds_sig_pkg::sample_t       stat_max,
    input  logic [`DDS_DATA_W-1:0]     stat_count
);

    // unity gain, 1.0 with 8 fraction bits
    localparam logic [`DDS_GAIN_W-1:0] GAIN_UNITY = `DDS_GAIN_W'(256);

    dds_reg_pkg::reg_addr_e     addr;
    dds_reg_pkg::fm_cfg_t       fm_cfg_q;
    dds_reg_pkg::fm_cfg_t       wr_fm;
    dds_reg_pkg::stat_cfg_t     wr_stat;
    dds_reg_pkg::stat_minmax_t  rd_minmax;
    logic                       addr_hit;
    logic                       wr_en;
    logic                       rd_en;
    logic [`DDS_DATA_W-1:0]     rd_data;

    assign addr = dds_reg_pkg::reg_addr_e'(paddr);

    // word aligned and inside the register window
    assign addr_hit = (paddr[1:0] == 2'b00) && (paddr[`DDS_ADDR_W-1:2] < `DDS_REG_COUNT);

    // no wait states, access phase is the write strobe
    assign wr_en = psel && penable && pwrite && addr_hit;
    assign rd_en = psel && !pwrite && addr_hit;

    assign wr_fm   = pwdata;
    assign wr_stat = pwdata;

    // fm fields straight out of the stored word
    assign fm_src  = dds_sig_pkg::fm_src_e'(fm_cfg_q.src);
    assign fm_raw  = fm_cfg_q.raw;
    assign fm_gain = fm_cfg_q.gain;

    always_ff @(posedge clk) begin
        if (rst) begin
            src_sel     <= dds_sig_pkg::SRC_RAW;
            raw         <= '0;
            step        <= '0;
            fm_cfg_q    <= '0;
            gain        <= GAIN_UNITY;
            offset      <= '0;
            phase_clr   <= 1'b0;
            stat_clear  <= 1'b0;
            stat_enable <= 1'b0;
            stat_limit  <= '0;
        end else begin
            // pulses last one cycle
            phase_clr  <= 1'b0;
            stat_clear <= 1'b0;
            if (wr_en) begin
                case (addr)
                    dds_reg_pkg::REG_SRC: begin
                        src_sel <= dds_sig_pkg::src_sel_e'(pwdata[2:0]);
                    end
                    dds_reg_pkg::REG_RAW: begin
                        raw <= pwdata[`DDS_SAMPLE_W-1:0];
                    end
                    dds_reg_pkg::REG_STEP: begin
                        step <= pwdata[`DDS_PHASE_W-1:0];
                    end
                    dds_reg_pkg::REG_FM_CFG: begin
                        fm_cfg_q      <= wr_fm;
                        // reserved bits read back as zero
                        fm_cfg_q.rsvd <= '0;
                    end
                    dds_reg_pkg::REG_GAIN: begin
                        gain <= pwdata[`DDS_GAIN_W-1:0];
                    end
                    dds_reg_pkg::REG_OFFSET: begin
                        offset <= pwdata[`DDS_SAMPLE_W-1:0];
                    end
                    dds_reg_pkg::REG_PHASE_CLR: begin
                        // any data value clears the phase
                        phase_clr <= 1'b1;
                    end
                    dds_reg_pkg::REG_STAT_CFG: begin
                        stat_clear  <= wr_stat.clear;
                        stat_enable <= wr_stat.enable;
                    end
                    dds_reg_pkg::REG_STAT_LIMIT: begin
                        stat_limit <= pwdata;
                    end
                    default: begin
                        // read only or unmapped, write dropped
                    end
                endcase
            end
        end
    end

    always_comb begin
        rd_minmax      = '0;
        rd_minmax.min  = stat_min;
        rd_minmax.max  = stat_max;
        rd_data        = '0;
        case (addr)
            dds_reg_pkg::REG_SRC:         rd_data[2:0] = src_sel;
            dds_reg_pkg::REG_RAW:         rd_data[`DDS_SAMPLE_W-1:0] = raw;
            dds_reg_pkg::REG_STEP:        rd_data[`DDS_PHASE_W-1:0] = step;
            dds_reg_pkg::REG_FM_CFG:      rd_data = fm_cfg_q;
            dds_reg_pkg::REG_GAIN:        rd_data[`DDS_GAIN_W-1:0] = gain;
            dds_reg_pkg::REG_OFFSET:      rd_data[`DDS_SAMPLE_W-1:0] = offset;
            // clear bit is a strobe, only enable is stored
            dds_reg_pkg::REG_STAT_CFG:    rd_data[1] = stat_enable;
            dds_reg_pkg::REG_STAT_LIMIT:  rd_data = stat_limit;
            dds_reg_pkg::REG_STAT_MINMAX: rd_data = rd_minmax;
            dds_reg_pkg::REG_STAT_COUNT:  rd_data = stat_count;
            default:                      rd_data = '0;
        endcase
    end

    // read data only while a read is addressed
    assign prdata = rd_en ? rd_data : '0;

endmodule

/* hw/dds_core.sv */
`timescale 1ns/1ps
`include "dds_params.svh"

module dds_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`DDS_PHASE_W-1:0]  step,
    input  logic                     phase_clr,
    input  dds_sig_pkg::sample_t     fm_sample,
    input  logic [`DDS_GAIN_W-1:0]   fm_gain,
    output dds_sig_pkg::sample_t     sample
);

    localparam int  LUT_DEPTH = 2 ** `DDS_LUT_AW;
    localparam int  PROD_W    = `DDS_SAMPLE_W + `DDS_GAIN_W;
    localparam real PI        = 3.14159265358979323846;

    typedef dds_sig_pkg::sample_t lut_t [LUT_DEPTH];

    // one full period, amplitude is the sample full scale
    function automatic lut_t build_lut();
        lut_t t;
        real  amp;
        real  val;
        int   k;
        amp = real'(dds_sig_pkg::SAMPLE_MAX);
        for (k = 0; k < LUT_DEPTH; k++) begin
            val = amp * $sin(2.0 * PI * k / LUT_DEPTH);
            // round half away from zero
            if (val >= 0.0) begin
                t[k] = dds_sig_pkg::sample_t'($rtoi(val + 0.5));
            end else begin
                t[k] = dds_sig_pkg::sample_t'(-$rtoi(0.5 - val));
            end
        end
        return t;
    endfunction

    localparam lut_t SINE_LUT = build_lut();

    logic signed [PROD_W-1:0]       fm_prod;
    logic [`DDS_PHASE_W-1:0]        fm_term;
    logic [`DDS_PHASE_W-1:0]        phase;

    // signed fm sample times signed fm gain
    assign fm_prod = fm_sample * $signed(fm_gain);

    // sign extend to phase width, then scale up into the step range
    assign fm_term = `DDS_PHASE_W'(fm_prod) << `DDS_FM_SHIFT;

    always_ff @(posedge clk) begin
        if (rst || phase_clr) begin
            phase <= '0;
        end else begin
            phase <= phase + step + fm_term;
        end
    end

    // table read is registered
    // top phase bits pick the entry
    always_ff @(posedge clk) begin
        sample <= SINE_LUT[phase[`DDS_PHASE_W-1 -: `DDS_LUT_AW]];
    end

endmodule

/* hw/prbs_gen.sv */
`timescale 1ns/1ps
`include "dds_params.svh"

module prbs_gen (
    input  logic                  clk,
    input  logic                  rst,
    output dds_sig_pkg::sample_t  sample
);

    // galois taps for x^8 + x^6 + x^5 + x^4 + 1
    localparam logic [`DDS_SAMPLE_W-1:0] FB_MASK = 8'hB8;

    logic [`DDS_SAMPLE_W-1:0] lfsr;

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= `DDS_PRBS_SEED;
        end else if (lfsr[0]) begin
            // bit shifted out is 1, fold the taps in
            lfsr <= (lfsr >> 1) ^ FB_MASK;
        end else begin
            lfsr <= lfsr >> 1;
        end
    end

    // state goes out as a signed sample
    assign sample = dds_sig_pkg::sample_t'(lfsr);

endmodule

/* hw/gain_offset_clamp.sv */
`timescale 1ns/1ps
`include "dds_params.svh"

module gain_offset_clamp (
    input  logic                    clk,
    input  logic                    rst,
    input  dds_sig_pkg::sample_t    sample_in,
    input  logic [`DDS_GAIN_W-1:0]  gain,
    input  dds_sig_pkg::sample_t    offset,
    output dds_sig_pkg::sample_t    sample_out
);

    // gain fraction bits
    localparam int GAIN_FRAC = 8;
    // extra bit keeps the unsigned gain positive
    localparam int PROD_W    = `DDS_SAMPLE_W + `DDS_GAIN_W + 1;
    localparam int SUM_W     = PROD_W + 1;

    localparam logic signed [SUM_W-1:0] SUM_MAX = SUM_W'(dds_sig_pkg::SAMPLE_MAX);
    localparam logic signed [SUM_W-1:0] SUM_MIN = SUM_W'(dds_sig_pkg::SAMPLE_MIN);

    logic signed [PROD_W-1:0] prod;
    logic signed [SUM_W-1:0]  sum;

    assign prod = sample_in * $signed({1'b0, gain});

    // drop the fraction, add the offset at full width
    assign sum = SUM_W'(prod >>> GAIN_FRAC) + SUM_W'(offset);

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_out <= '0;
        end else if (sum > SUM_MAX) begin
            sample_out <= dds_sig_pkg::SAMPLE_MAX;
        end else if (sum < SUM_MIN) begin
            sample_out <= dds_sig_pkg::SAMPLE_MIN;
        end else begin
            sample_out <= dds_sig_pkg::sample_t'(sum);
        end
    end

endmodule

/* hw/sig_stat.sv */
`timescale 1ns/1ps
`include "dds_params.svh"

module sig_stat (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear,
    input  logic                    enable,
    input  dds_sig_pkg::sample_t    sample,
    input  logic [`DDS_DATA_W-1:0]  limit,
    output dds_sig_pkg::sample_t    min,
    output dds_sig_pkg::sample_t    max,
    output logic [`DDS_DATA_W-1:0]  count
);

    logic take;

    // one sample per cycle, stop once the limit is reached
    assign take = enable && (count < limit);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            // empty range, first sample sets both ends
            min   <= dds_sig_pkg::SAMPLE_MAX;
            max   <= dds_sig_pkg::SAMPLE_MIN;
            count <= '0;
        end else if (take) begin
            if (sample < min) begin
                min <= sample;
            end
            if (sample > max) begin
                max <= sample;
            end
            count <= count + 1'b1;
        end
    end

endmodule

/* hw/dds_block.sv */
`timescale 1ns/1ps
`include "dds_params.svh"

module dds_block (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`DDS_ADDR_W-1:0]  paddr,
    input  logic [`DDS_DATA_W-1:0]  pwdata,
    output logic [`DDS_DATA_W-1:0]  prdata,
    input  dds_sig_pkg::sample_t    ina,
    input  dds_sig_pkg::sample_t    inb,
    output dds_sig_pkg::sample_t    sample_out
);

    // configuration from the register file
    dds_sig_pkg::src_sel_e       src_sel;
    dds_sig_pkg::sample_t        raw;
    logic [`DDS_PHASE_W-1:0]     step;
    dds_sig_pkg::fm_src_e        fm_src;
    dds_sig_pkg::sample_t        fm_raw;
    logic [`DDS_GAIN_W-1:0]      fm_gain;
    logic [`DDS_GAIN_W-1:0]      gain;
    dds_sig_pkg::sample_t        offset;
    logic                        phase_clr;
    logic                        stat_clear;
    logic                        stat_enable;
    logic [`DDS_DATA_W-1:0]      stat_limit;

    // statistics back to software
    dds_sig_pkg::sample_t        stat_min;
    dds_sig_pkg::sample_t        stat_max;
    logic [`DDS_DATA_W-1:0]      stat_count;

    // sources and selected samples
    dds_sig_pkg::sample_t        fm_sample;
    dds_sig_pkg::sample_t        dds_sample;
    dds_sig_pkg::sample_t        prbs_sample;
    dds_sig_pkg::sample_t        sel_sample;

    dds_regs dds_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .src_sel     (src_sel),
        .raw         (raw),
        .step        (step),
        .fm_src      (fm_src),
        .fm_raw      (fm_raw),
        .fm_gain     (fm_gain),
        .gain        (gain),
        .offset      (offset),
        .phase_clr   (phase_clr),
        .stat_clear  (stat_clear),
        .stat_enable (stat_enable),
        .stat_limit  (stat_limit),
        .stat_min    (stat_min),
        .stat_max    (stat_max),
        .stat_count  (stat_count)
    );

    // fm modulation source
    always_comb begin
        case (fm_src)
            dds_sig_pkg::FM_RAW: fm_sample = fm_raw;
            dds_sig_pkg::FM_INA: fm_sample = ina;
            dds_sig_pkg::FM_INB: fm_sample = inb;
            default:             fm_sample = '0;
        endcase
    end

    dds_core dds_core_inst (
        .clk       (clk),
        .rst       (rst),
        .step      (step),
        .phase_clr (phase_clr),
        .fm_sample (fm_sample),
        .fm_gain   (fm_gain),
        .sample    (dds_sample)
    );

    prbs_gen prbs_gen_inst (
        .clk    (clk),
        .rst    (rst),
        .sample (prbs_sample)
    );

    // output source, unused codes give zero
    always_comb begin
        case (src_sel)
            dds_sig_pkg::SRC_RAW:  sel_sample = raw;
            dds_sig_pkg::SRC_INA:  sel_sample = ina;
            dds_sig_pkg::SRC_INB:  sel_sample = inb;
            dds_sig_pkg::SRC_DDS:  sel_sample = dds_sample;
            dds_sig_pkg::SRC_PRBS: sel_sample = prbs_sample;
            default:               sel_sample = '0;
        endcase
    end

    gain_offset_clamp gain_offset_clamp_inst (
        .clk        (clk),
        .rst        (rst),
        .sample_in  (sel_sample),
        .gain       (gain),
        .offset     (offset),
        .sample_out (sample_out)
    );

    // stats watch the final output
    sig_stat sig_stat_inst (
        .clk    (clk),
        .rst    (rst),
        .clear  (stat_clear),
        .enable (stat_enable),
        .sample (sample_out),
        .limit  (stat_limit),
        .min    (stat_min),
        .max    (stat_max),
        .count  (stat_count)
    );

endmodule

/* tests/dds_block_chk.sv */
`timescale 1ns/1ps
`include "dds_params.svh"

module dds_block_chk (
    input logic                     clk,
    input logic                     rst,
    input logic                     psel,
    input logic                     penable,
    input logic                     pwrite,
    input logic [`DDS_DATA_W-1:0]   prdata,
    input logic [`DDS_SAMPLE_W-1:0] sample_out,
    input logic                     phase_clr,
    input logic                     stat_clear,
    input logic [`DDS_DATA_W-1:0]   stat_count,
    input logic [`DDS_DATA_W-1:0]   stat_limit
);

    // set by any failed property
    logic assert_failed = 1'b0;
    // first accepted apb write since reset
    logic configured;

    always_ff @(posedge clk) begin
        if (rst) begin
            configured <= 1'b0;
        end else if (psel && penable && pwrite) begin
            configured <= 1'b1;
        end
    end

    // bus idle means zero read data
    prdata_idle_zero: assert property (@(posedge clk) disable iff (rst)
        !psel |-> prdata == '0)
        else begin
            $error("prdata nonzero while psel is low");
            assert_failed = 1'b1;
        end

    // counter saturates at the limit
    count_within_limit: assert property (@(posedge clk) disable iff (rst)
        stat_count <= stat_limit)
        else begin
            $error("stat_count above stat_limit");
            assert_failed = 1'b1;
        end

    phase_clr_single: assert property (@(posedge clk) disable iff (rst)
        phase_clr |=> !phase_clr)
        else begin
            $error("phase_clr high for two cycles");
            assert_failed = 1'b1;
        end

    stat_clear_single: assert property (@(posedge clk) disable iff (rst)
        stat_clear |=> !stat_clear)
        else begin
            $error("stat_clear high for two cycles");
            assert_failed = 1'b1;
        end

    // reset config gives raw 0 at unity gain
    quiet_until_config: assert property (@(posedge clk) disable iff (rst)
        !configured |-> sample_out == '0)
        else begin
            $error("sample_out moved before any register write");
            assert_failed = 1'b1;
        end

endmodule

bind dds_block dds_block_chk dds_block_chk_inst (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .prdata     (prdata),
    .sample_out (sample_out),
    .phase_clr  (phase_clr),
    .stat_clear (stat_clear),
    .stat_count (stat_count),
    .stat_limit (stat_limit)
);

/* tests/dds_block_tb.sv */
`timescale 1ns/1ps
`include "dds_params.svh"

module dds_block_tb;

    // rough cycle cost of each test
    localparam int RESET_CYCLES   = 10;
    localparam int REGS_CYCLES    = 60;
    localparam int CLAMP_CYCLES   = 170;
    localparam int INPUT_CYCLES   = 70;
    localparam int DDS_CYCLES     = 80;
    localparam int PRBS_CYCLES    = 35;
    localparam int STATS_CYCLES   = 100;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + REGS_CYCLES + CLAMP_CYCLES
        + INPUT_CYCLES + DDS_CYCLES + PRBS_CYCLES + STATS_CYCLES);

    // writable registers and their implemented bits
    localparam logic [7:0] RW_ADDR [8] = '{dds_reg_pkg::REG_SRC, dds_reg_pkg::REG_RAW,
        dds_reg_pkg::REG_STEP, dds_reg_pkg::REG_FM_CFG, dds_reg_pkg::REG_GAIN,
        dds_reg_pkg::REG_OFFSET, dds_reg_pkg::REG_STAT_CFG, dds_reg_pkg::REG_STAT_LIMIT};
    localparam logic [31:0] RW_MASK [8] = '{32'h7, 32'hFF, 32'hFFFF_FFFF, 32'hFFFF_FF03,
        32'hFFFF, 32'hFF, 32'h2, 32'hFFFF_FFFF};
    localparam logic [31:0] QUARTER_STEP = 32'h4000_0000;

    logic                   clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`DDS_ADDR_W-1:0] paddr;
    logic [`DDS_DATA_W-1:0] pwdata;
    logic [`DDS_DATA_W-1:0] prdata;
    logic [7:0]             ina;
    logic [7:0]             inb;
    logic [7:0]             sample_out;
    logic [31:0]            rng = 32'd48298;
    int                     cycle_count = 0;

    dds_block dds_block_inst (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .ina        (ina),
        .inb        (inb),
        .sample_out (sample_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // u8.8 gain, floor shift, then clamp to a signed byte
    function automatic logic [7:0] scaled_sample(input logic [7:0] s, input logic [15:0] g,
                                                 input logic [7:0] o);
        int v;
        v = (int'($signed(s)) * int'(g)) >>> 8;
        v = v + int'($signed(o));
        if (v > 127) begin
            v = 127;
        end else if (v < -128) begin
            v = -128;
        end
        return v[7:0];
    endfunction

    // galois step, taps 0xB8
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return (s >> 1) ^ (s[0] ? 8'hB8 : 8'h00);
    endfunction

    // sine at quarter turns: 0, 127, 0, -127
    function automatic logic [7:0] quarter_sine(input int k);
        case (k % 4)
            1:       return 8'h7F;
            3:       return 8'h81;
            default: return 8'h00;
        endcase
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s expected 0x%08h actual 0x%08h", name, expected, actual);
            stop_with_failure("output did not match the reference");
        end
    endtask

    // all tasks start and end 1 ns after a rising edge
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // prdata settled during the access phase
        @(posedge clk);
        data = prdata;
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic take_sample(output logic [7:0] s);
        @(posedge clk);
        s = sample_out;
        #1;
    endtask

    task automatic run_clamp_case(input string name, input logic [7:0] r,
                                  input logic [15:0] g, input logic [7:0] o);
        logic [7:0] s;
        write_reg(dds_reg_pkg::REG_RAW, 32'(r));
        write_reg(dds_reg_pkg::REG_GAIN, 32'(g));
        write_reg(dds_reg_pkg::REG_OFFSET, 32'(o));
        wait_cycles(4);
        take_sample(s);
        check_value(name, 32'(scaled_sample(r, g, o)), 32'(s));
    endtask

    // hold a random input steady, output must follow it
    task automatic run_input_case(input string name, input logic use_b);
        logic [7:0] s;
        int         i;
        for (i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            ina = rng[7:0];
            inb = rng[15:8];
            wait_cycles(4);
            take_sample(s);
            check_value(name, 32'(use_b ? inb : ina), 32'(s));
        end
    endtask

    // lock on a 0 then 127, then follow the quarter pattern
    task automatic check_sine(input string name);
        logic [7:0] prev;
        logic [7:0] cur;
        bit         found;
        int         k;
        found = 1'b0;
        take_sample(prev);
        for (k = 0; k < 16 && !found; k++) begin
            take_sample(cur);
            found = (prev == 8'h00) && (cur == 8'h7F);
            prev  = cur;
        end
        if (!found) begin
            stop_with_failure($sformatf("%s never showed 0 followed by 127", name));
        end
        for (k = 2; k < 10; k++) begin
            take_sample(cur);
            check_value(name, 32'(quarter_sine(k)), 32'(cur));
        end
    endtask

    task automatic wait_stat_count(input logic [31:0] target);
        logic [31:0] rd;
        rd = '0;
        while (rd != target) begin
            read_reg(dds_reg_pkg::REG_STAT_COUNT, rd);
        end
    endtask

    // timeout and bound assertion watch
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (dds_block_inst.dds_block_chk_inst.assert_failed) begin
            stop_with_failure("a bound assertion failed");
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] wr_val [8];
        logic [7:0]  s;
        logic [7:0]  prev;
        logic [7:0]  r8;
        int          i;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        ina     = '0;
        inb     = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset values, nothing written yet, only gain is nonzero
        for (i = 0; i < 8; i++) begin
            read_reg(RW_ADDR[i], rd);
            check_value($sformatf("reset 0x%02h", RW_ADDR[i]),
                        (RW_ADDR[i] == dds_reg_pkg::REG_GAIN) ? 32'h100 : 32'h0, rd);
        end
        read_reg(dds_reg_pkg::REG_STAT_MINMAX, rd);
        check_value("reset minmax", 32'h0000_807F, rd);
        read_reg(dds_reg_pkg::REG_STAT_COUNT, rd);
        check_value("reset count", 32'h0, rd);

        // random write, masked read back
        for (i = 0; i < 8; i++) begin
            rng       = xorshift(rng);
            wr_val[i] = rng;
            write_reg(RW_ADDR[i], rng);
        end
        for (i = 0; i < 8; i++) begin
            read_reg(RW_ADDR[i], rd);
            check_value($sformatf("readback 0x%02h", RW_ADDR[i]), wr_val[i] & RW_MASK[i], rd);
        end
        read_reg(8'h2C, rd);
        check_value("unmapped 0x2c", 32'h0, rd);
        read_reg(8'hFC, rd);
        check_value("unmapped 0xfc", 32'h0, rd);
        read_reg(8'h06, rd);
        check_value("misaligned 0x06", 32'h0, rd);
        // stats back to empty and stopped
        write_reg(dds_reg_pkg::REG_STAT_CFG, 32'h1);

        // gain, offset, saturation
        write_reg(dds_reg_pkg::REG_SRC, 32'(dds_sig_pkg::SRC_RAW));
        for (i = 0; i < 12; i++) begin
            rng = xorshift(rng);
            run_clamp_case("clamp random", rng[7:0], {6'd0, rng[17:8]}, rng[31:24]);
        end
        run_clamp_case("clamp high", 8'd100, 16'd512, 8'd0);
        run_clamp_case("clamp low", 8'h9C, 16'd512, 8'd0);
        run_clamp_case("clamp offset", 8'd127, 16'd256, 8'd127);

        // input sources at unity gain
        write_reg(dds_reg_pkg::REG_GAIN, 32'd256);
        write_reg(dds_reg_pkg::REG_OFFSET, 32'd0);
        write_reg(dds_reg_pkg::REG_SRC, 32'(dds_sig_pkg::SRC_INA));
        run_input_case("source ina", 1'b0);
        write_reg(dds_reg_pkg::REG_SRC, 32'(dds_sig_pkg::SRC_INB));
        run_input_case("source inb", 1'b1);
        write_reg(dds_reg_pkg::REG_SRC, 32'(dds_sig_pkg::SRC_ZERO));
        wait_cycles(4);
        take_sample(s);
        check_value("source zero", 32'h0, 32'(s));

        // quarter turn per cycle from the step
        write_reg(dds_reg_pkg::REG_SRC, 32'(dds_sig_pkg::SRC_DDS));
        write_reg(dds_reg_pkg::REG_FM_CFG, 32'(dds_sig_pkg::FM_OFF));
        write_reg(dds_reg_pkg::REG_STEP, QUARTER_STEP);
        write_reg(dds_reg_pkg::REG_PHASE_CLR, 32'h0);
        wait_cycles(4);
        check_sine("dds step");
        // same rate from fm: 64 * 256 << 16
        write_reg(dds_reg_pkg::REG_STEP, 32'h0);
        write_reg(dds_reg_pkg::REG_FM_CFG, {16'd256, 8'd64, 6'd0, 2'(dds_sig_pkg::FM_RAW)});
        write_reg(dds_reg_pkg::REG_PHASE_CLR, 32'h0);
        wait_cycles(4);
        check_sine("dds fm");

        // prbs, model runs on from the first sample
        write_reg(dds_reg_pkg::REG_SRC, 32'(dds_sig_pkg::SRC_PRBS));
        wait_cycles(4);
        take_sample(prev);
        // galois lfsr from a nonzero seed never reaches zero
        assert (prev != 8'h00) else begin
            stop_with_failure("prbs output is zero");
        end
        for (i = 0; i < 20; i++) begin
            prev = lfsr_next(prev);
            take_sample(s);
            check_value("prbs step", 32'(prev), 32'(s));
        end

        // statistics on a constant raw value
        rng = xorshift(rng);
        r8  = rng[7:0];
        write_reg(dds_reg_pkg::REG_SRC, 32'(dds_sig_pkg::SRC_RAW));
        write_reg(dds_reg_pkg::REG_RAW, 32'(r8));
        write_reg(dds_reg_pkg::REG_STAT_CFG, 32'h1);
        write_reg(dds_reg_pkg::REG_STAT_LIMIT, 32'd20);
        wait_cycles(4);
        write_reg(dds_reg_pkg::REG_STAT_CFG, 32'h3);
        wait_stat_count(32'd20);
        read_reg(dds_reg_pkg::REG_STAT_MINMAX, rd);
        check_value("stat raw minmax", {16'd0, r8, r8}, rd);
        // count holds at the limit
        wait_cycles(8);
        read_reg(dds_reg_pkg::REG_STAT_COUNT, rd);
        check_value("stat count", 32'd20, rd);
        // statistics on the quarter-turn sine
        write_reg(dds_reg_pkg::REG_STAT_CFG, 32'h1);
        write_reg(dds_reg_pkg::REG_FM_CFG, 32'(dds_sig_pkg::FM_OFF));
        write_reg(dds_reg_pkg::REG_STEP, QUARTER_STEP);
        write_reg(dds_reg_pkg::REG_SRC, 32'(dds_sig_pkg::SRC_DDS));
        wait_cycles(4);
        write_reg(dds_reg_pkg::REG_STAT_CFG, 32'h3);
        wait_stat_count(32'd20);
        read_reg(dds_reg_pkg::REG_STAT_MINMAX, rd);
        check_value("stat dds minmax", 32'h0000_7F81, rd);

        if (dds_block_inst.dds_block_chk_inst.assert_failed) begin
            stop_with_failure("a bound assertion failed");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* dds_block.f */
+incdir+hw
hw/dds_reg_pkg.sv
hw/dds_sig_pkg.sv
hw/dds_regs.sv
hw/dds_core.sv
hw/prbs_gen.sv
hw/gain_offset_clamp.sv
hw/sig_stat.sv
hw/dds_block.sv
tests/dds_block_chk.sv
tests/dds_block_tb.sv

/* Bender.yml */
package:
  name: dds_block

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dds_reg_pkg.sv
      - hw/dds_sig_pkg.sv
      - hw/dds_regs.sv
      - hw/dds_core.sv
      - hw/prbs_gen.sv
      - hw/gain_offset_clamp.sv
      - hw/sig_stat.sv
      - hw/dds_block.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/dds_block_chk.sv
      - tests/dds_block_tb.sv
